//--- design/coreControl.sv
`timescale 1ns/100ps

module coreControl (
    input  logic            clk,
    input  logic            rstN,
    input  logic            PSEL,
    input  logic            PENABLE,
    input  logic            PWRITE,
    input  rvPkg::apbAddr_t PADDR,
    input  rvPkg::word_t    PWDATA,
    input  logic            halted,
    input  rvPkg::word_t    a0,
    input  rvPkg::word_t    retired,
    output rvPkg::word_t    PRDATA,
    output logic            PREADY,
    output logic            PSLVERR,
    output logic            run,
    output logic            coreClear,
    output logic            imemWe,
    output rvPkg::memAddr_t imemAddr,
    output rvPkg::word_t    imemData
);
    import rvPkg::*;

    typedef enum logic [1:0] {IDLE, RUN, DONE} runState_t;

    runState_t state;
    memAddr_t  imemPtr;
    logic      access;
    logic      mapped;
    logic      readOnly;
    logic      lockedWr;
    logic      wrOk;

    assign access   = PSEL & PENABLE;
    assign mapped   = PADDR inside {REG_CTRL, REG_STATUS, REG_A0, REG_RETIRED,
                                    REG_IMEM_ADDR, REG_IMEM_DATA};
    assign readOnly = PADDR inside {REG_STATUS, REG_A0, REG_RETIRED};
    assign lockedWr = (state == RUN) && (PADDR inside {REG_IMEM_ADDR, REG_IMEM_DATA});
    assign PSLVERR  = access & (~mapped | (PWRITE & (readOnly | lockedWr)));
    assign wrOk     = access & PWRITE & ~PSLVERR;
    assign PREADY   = 1'b1;
    assign run      = (state == RUN);

    always_comb begin
        case (PADDR)
            REG_CTRL:      PRDATA = {31'b0, run};
            REG_STATUS:    PRDATA = {30'b0, state == RUN, state == DONE};
            REG_A0:        PRDATA = a0;
            REG_RETIRED:   PRDATA = retired;
            REG_IMEM_ADDR: PRDATA = {26'b0, imemPtr};
            default:       PRDATA = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= IDLE;
            coreClear <= 1'b0;
            imemWe    <= 1'b0;
            imemPtr   <= '0;
        end else begin
            coreClear <= 1'b0;
            imemWe    <= 1'b0;
            // halted is stale while the clear pulse is out
            if (state == RUN && halted && !coreClear) begin
                state <= DONE;
            end
            if (wrOk) begin
                case (PADDR)
                    REG_CTRL: begin
                        if (!PWDATA[0]) begin
                            state <= IDLE;
                        end else if (state != RUN) begin
                            state     <= RUN;
                            coreClear <= 1'b1;
                        end
                    end
                    // word index, not byte address
                    REG_IMEM_ADDR: imemPtr <= PWDATA[5:0];
                    REG_IMEM_DATA: begin
                        imemWe  <= 1'b1;
                        imemPtr <= imemPtr + 6'd1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // write port payload, valid with imemWe
    always_ff @(posedge clk) begin
        if (wrOk && PADDR == REG_IMEM_DATA) begin
            imemAddr <= imemPtr;
            imemData <= PWDATA;
        end
    end

endmodule

//--- design/decodeUnit.sv
`timescale 1ns/100ps

module decodeUnit (
    input  rvPkg::word_t       instr,
    output rvPkg::decodeCtrl_t ctrl,
    output rvPkg::word_t       immExt
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immJ;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // subOp only set for R-type, ADDI has no subtract form
    function automatic aluCtrl_t aluDecode(logic [2:0] f3, logic subOp);
        aluCtrl_t code;
        case (f3)
            3'b000:  code = subOp ? ALU_SUB : ALU_ADD;
            3'b010:  code = ALU_SLT;
            3'b100:  code = ALU_XOR;
            3'b110:  code = ALU_OR;
            3'b111:  code = ALU_AND;
            default: code = ALU_ADD;
        endcase
        return code;
    endfunction

    always_comb begin
        ctrl         = '0;
        ctrl.aluCtrl = ALU_ADD;
        immExt       = '0;
        case (opcode)
            OP_R: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = aluDecode(funct3, funct7b5);
            end
            OP_I: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluCtrl  = aluDecode(funct3, 1'b0);
                immExt        = immI;
            end
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = RES_MEM;
                ctrl.aluSrc    = 1'b1;
                immExt         = immI;
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immExt        = immS;
            end
            OP_BRANCH: begin
                // funct3 bit 0 separates BNE from BEQ
                ctrl.branch   = 1'b1;
                ctrl.branchNe = funct3[0];
                ctrl.aluCtrl  = ALU_SUB;
                immExt        = immB;
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = RES_PC4;
                ctrl.jump      = 1'b1;
                immExt         = immJ;
            end
            OP_SYSTEM: begin
                // funct12 of 1 is EBREAK
                ctrl.halt = (instr[31:20] == 12'h001);
            end
            default: begin
                // unknown opcode, leave as bubble
                ctrl = '0;
            end
        endcase
    end

endmodule

//--- design/executeUnit.sv
`timescale 1ns/100ps

module executeUnit (
    input  rvPkg::idEx_t     idEx,
    input  rvPkg::word_t     aluResultM,
    input  rvPkg::word_t     resultW,
    input  logic [1:0]       forwardA,
    input  logic [1:0]       forwardB,
    output rvPkg::exResult_t ex
);
    import rvPkg::*;

    word_t srcA;
    word_t regB;
    word_t srcB;
    word_t aluOut;
    logic  equal;

    function automatic word_t forwardMux(
        logic [1:0] sel,
        word_t      regVal,
        word_t      memVal,
        word_t      wbVal
    );
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = forwardMux(forwardA, idEx.rd1, aluResultM, resultW);
    assign regB = forwardMux(forwardB, idEx.rd2, aluResultM, resultW);
    assign srcB = idEx.ctrl.aluSrc ? idEx.immExt : regB;

    always_comb begin
        case (idEx.ctrl.aluCtrl)
            ALU_SUB: aluOut = srcA - srcB;
            ALU_AND: aluOut = srcA & srcB;
            ALU_OR:  aluOut = srcA | srcB;
            ALU_XOR: aluOut = srcA ^ srcB;
            ALU_SLT: aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            default: aluOut = srcA + srcB;
        endcase
    end

    // branch compare on forwarded registers, not on the ALU output
    assign equal = (srcA == regB);

    always_comb begin
        // JAL carries its link value here so memory-stage forwarding sees it
        ex.aluResult  = idEx.ctrl.jump ? idEx.pcPlus4 : aluOut;
        ex.writeData  = regB;
        ex.pcTarget   = idEx.pc + idEx.immExt;
        ex.takeBranch = idEx.ctrl.jump | (idEx.ctrl.branch & (equal ^ idEx.ctrl.branchNe));
    end

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  rvPkg::regAddr_t   rs1D,
    input  rvPkg::regAddr_t   rs2D,
    input  rvPkg::idEx_t      idEx,
    input  rvPkg::exMem_t     exMem,
    input  rvPkg::memWb_t     memWb,
    input  logic              takeBranch,
    output rvPkg::hazardCtl_t hz
);
    import rvPkg::*;

    logic memHitA;
    logic memHitB;
    logic wbHitA;
    logic wbHitB;
    logic loadUse;

    // x0 never forwards, the rd check covers it
    assign memHitA = exMem.regWrite && (exMem.rd != '0) && (exMem.rd == idEx.rs1);
    assign memHitB = exMem.regWrite && (exMem.rd != '0) && (exMem.rd == idEx.rs2);
    assign wbHitA  = memWb.regWrite && (memWb.rd != '0) && (memWb.rd == idEx.rs1);
    assign wbHitB  = memWb.regWrite && (memWb.rd != '0) && (memWb.rd == idEx.rs2);

    // load in execute feeding the instruction in decode
    assign loadUse = (idEx.ctrl.resultSrc == RES_MEM) && (idEx.rd != '0) &&
                     ((idEx.rd == rs1D) || (idEx.rd == rs2D));

    always_comb begin
        // newest value wins, so memory stage is checked first
        if (memHitA) begin
            hz.forwardA = FWD_MEM;
        end else if (wbHitA) begin
            hz.forwardA = FWD_WB;
        end else begin
            hz.forwardA = FWD_REG;
        end
        if (memHitB) begin
            hz.forwardB = FWD_MEM;
        end else if (wbHitB) begin
            hz.forwardB = FWD_WB;
        end else begin
            hz.forwardB = FWD_REG;
        end
        hz.stallF = loadUse;
        hz.stallD = loadUse;
        hz.flushD = takeBranch;
        hz.flushE = loadUse | takeBranch;
    end

endmodule

//--- design/pipeCore.sv
`timescale 1ns/100ps

module pipeCore (
    input  logic            clk,
    input  logic            rstN,
    input  logic            run,
    input  logic            coreClear,
    input  logic            imemWe,
    input  rvPkg::memAddr_t imemAddr,
    input  rvPkg::word_t    imemData,
    output logic            halted,
    output rvPkg::word_t    a0,
    output rvPkg::word_t    retired
);
    import rvPkg::*;

    word_t       imem [64];
    word_t       dmem [64];
    word_t       rf [32];
    word_t       pc;
    word_t       pcPlus4;
    word_t       instrF;
    word_t       instrD;
    word_t       pcD;
    word_t       pcPlus4D;
    logic        validD;
    logic        validE;
    logic        validM;
    logic        validW;
    decodeCtrl_t ctrlD;
    word_t       immExtD;
    regAddr_t    rs1D;
    regAddr_t    rs2D;
    word_t       rd1D;
    word_t       rd2D;
    word_t       resultW;
    logic        wbWrite;
    logic        step;
    idEx_t       idEx;
    exResult_t   ex;
    exMem_t      exMem;
    memWb_t      memWb;
    hazardCtl_t  hz;

    // pipeline freezes with EBREAK sitting in writeback
    assign step    = run & ~memWb.halt;
    assign halted  = memWb.halt;
    assign pcPlus4 = pc + 32'd4;
    assign instrF  = imem[pc[7:2]];
    assign rs1D    = instrD[19:15];
    assign rs2D    = instrD[24:20];

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    decodeUnit uDecode (.instr(instrD), .ctrl(ctrlD), .immExt(immExtD));

    // register file, write-first so decode sees the writeback value
    assign wbWrite = run && memWb.regWrite && (memWb.rd != '0);
    assign rd1D = (wbWrite && memWb.rd == rs1D) ? resultW : ((rs1D == '0) ? '0 : rf[rs1D]);
    assign rd2D = (wbWrite && memWb.rd == rs2D) ? resultW : ((rs2D == '0) ? '0 : rf[rs2D]);
    assign a0   = rf[10];

    always_ff @(posedge clk) begin
        if (coreClear) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (wbWrite) begin
            rf[memWb.rd] <= resultW;
        end
    end

    hazardUnit uHazard (
        .rs1D(rs1D), .rs2D(rs2D), .idEx(idEx), .exMem(exMem), .memWb(memWb),
        .takeBranch(ex.takeBranch), .hz(hz)
    );

    executeUnit uExecute (
        .idEx(idEx), .aluResultM(exMem.aluResult), .resultW(resultW),
        .forwardA(hz.forwardA), .forwardB(hz.forwardB), .ex(ex)
    );

    always_ff @(posedge clk) begin
        if (step && exMem.memWrite) begin
            dmem[exMem.aluResult[7:2]] <= exMem.writeData;
        end
    end

    always_comb begin
        case (memWb.resultSrc)
            RES_MEM: resultW = memWb.readData;
            RES_PC4: resultW = memWb.pcPlus4;
            default: resultW = memWb.aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN || coreClear) begin
            pc       <= '0;
            instrD   <= '0;
            pcD      <= '0;
            pcPlus4D <= '0;
            {validD, validE, validM, validW} <= '0;
            idEx     <= '0;
            exMem    <= '0;
            memWb    <= '0;
        end else if (step) begin
            if (!hz.stallF) begin
                pc <= ex.takeBranch ? ex.pcTarget : pcPlus4;
            end
            if (hz.flushD) begin
                instrD <= '0;
                validD <= 1'b0;
            end else if (!hz.stallD) begin
                instrD   <= instrF;
                pcD      <= pc;
                pcPlus4D <= pcPlus4;
                validD   <= 1'b1;
            end
            if (hz.flushE) begin
                idEx   <= '0;
                validE <= 1'b0;
            end else begin
                idEx <= '{ctrl: ctrlD, pc: pcD, pcPlus4: pcPlus4D, rd1: rd1D, rd2: rd2D,
                          immExt: immExtD, rs1: rs1D, rs2: rs2D, rd: instrD[11:7]};
                validE <= validD;
            end
            exMem <= '{regWrite: idEx.ctrl.regWrite, resultSrc: idEx.ctrl.resultSrc,
                       memWrite: idEx.ctrl.memWrite, halt: idEx.ctrl.halt,
                       aluResult: ex.aluResult, writeData: ex.writeData,
                       pcPlus4: idEx.pcPlus4, rd: idEx.rd};
            validM <= validE;
            memWb <= '{regWrite: exMem.regWrite, resultSrc: exMem.resultSrc, halt: exMem.halt,
                       aluResult: exMem.aluResult, readData: dmem[exMem.aluResult[7:2]],
                       pcPlus4: exMem.pcPlus4, rd: exMem.rd};
            validW <= validM;
        end
    end

    // EBREAK counts once, on the edge where control drops run
    always_ff @(posedge clk) begin
        if (!rstN || coreClear) begin
            retired <= '0;
        end else if (run && validW) begin
            retired <= retired + 32'd1;
        end
    end

endmodule

//--- design/rvPkg.sv
package rvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  memAddr_t;
    typedef logic [3:0]  aluCtrl_t;
    typedef logic [7:0]  apbAddr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam aluCtrl_t ALU_ADD = 4'd0;
    localparam aluCtrl_t ALU_SUB = 4'd1;
    localparam aluCtrl_t ALU_AND = 4'd2;
    localparam aluCtrl_t ALU_OR  = 4'd3;
    localparam aluCtrl_t ALU_XOR = 4'd4;
    localparam aluCtrl_t ALU_SLT = 4'd5;

    // writeback source
    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;

    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_WB  = 2'd1;
    localparam logic [1:0] FWD_MEM = 2'd2;

    // APB register map, byte offsets
    localparam apbAddr_t REG_CTRL      = 8'h00;
    localparam apbAddr_t REG_STATUS    = 8'h04;
    localparam apbAddr_t REG_A0        = 8'h08;
    localparam apbAddr_t REG_RETIRED   = 8'h0C;
    localparam apbAddr_t REG_IMEM_ADDR = 8'h10;
    localparam apbAddr_t REG_IMEM_DATA = 8'h14;

    typedef struct packed {
        logic       regWrite;
        logic [1:0] resultSrc;
        logic       memWrite;
        logic       aluSrc;
        aluCtrl_t   aluCtrl;
        logic       branch;
        logic       branchNe;
        logic       jump;
        logic       halt;
    } decodeCtrl_t;

    typedef struct packed {
        decodeCtrl_t ctrl;
        word_t       pc;
        word_t       pcPlus4;
        word_t       rd1;
        word_t       rd2;
        word_t       immExt;
        regAddr_t    rs1;
        regAddr_t    rs2;
        regAddr_t    rd;
    } idEx_t;

    typedef struct packed {
        word_t aluResult;
        word_t writeData;
        word_t pcTarget;
        logic  takeBranch;
    } exResult_t;

    typedef struct packed {
        logic       regWrite;
        logic [1:0] resultSrc;
        logic       memWrite;
        logic       halt;
        word_t      aluResult;
        word_t      writeData;
        word_t      pcPlus4;
        regAddr_t   rd;
    } exMem_t;

    typedef struct packed {
        logic       regWrite;
        logic [1:0] resultSrc;
        logic       halt;
        word_t      aluResult;
        word_t      readData;
        word_t      pcPlus4;
        regAddr_t   rd;
    } memWb_t;

    typedef struct packed {
        logic [1:0] forwardA;
        logic [1:0] forwardB;
        logic       stallF;
        logic       stallD;
        logic       flushD;
        logic       flushE;
    } hazardCtl_t;

endpackage

//--- design/rvTop.sv
`timescale 1ns/100ps

module rvTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            PSEL,
    input  logic            PENABLE,
    input  logic            PWRITE,
    input  rvPkg::apbAddr_t PADDR,
    input  rvPkg::word_t    PWDATA,
    output rvPkg::word_t    PRDATA,
    output logic            PREADY,
    output logic            PSLVERR
);
    import rvPkg::*;

    logic     run;
    logic     coreClear;
    logic     imemWe;
    memAddr_t imemAddr;
    word_t    imemData;
    logic     halted;
    word_t    a0;
    word_t    retired;

    coreControl uControl (
        .clk(clk), .rstN(rstN),
        .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
        .halted(halted), .a0(a0), .retired(retired),
        .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
        .run(run), .coreClear(coreClear),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData)
    );

    pipeCore uCore (
        .clk(clk), .rstN(rstN), .run(run), .coreClear(coreClear),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .halted(halted), .a0(a0), .retired(retired)
    );

endmodule

//--- rvTop.f
design/rvPkg.sv
design/hazardUnit.sv
design/decodeUnit.sv
design/executeUnit.sv
design/pipeCore.sv
design/coreControl.sv
design/rvTop.sv
testbench/rvChecker.sv
testbench/rvTop_properties.sv
testbench/rvTop_tb.sv

//--- testbench/rvChecker.sv
`timescale 1ns/100ps

module rvChecker (
    input  logic            clk,
    input  logic            PSEL,
    input  logic            PENABLE,
    input  logic            PWRITE,
    input  rvPkg::apbAddr_t PADDR,
    input  rvPkg::word_t    PRDATA,
    input  logic            PREADY,
    input  logic            PSLVERR,
    input  logic            checkRead,
    input  rvPkg::word_t    expData,
    input  logic            expErr,
    output int              errorCount
);
    int errors;

    initial begin
        errors = 0;
    end

    assign errorCount = errors;

    // access phase, sampled mid-cycle
    always @(negedge clk) begin
        if (PSEL && PENABLE) begin
            if (PREADY !== 1'b1) begin
                $display("ERR PREADY addr 0x%02h: got 0x%0h expected 0x1", PADDR, PREADY);
                errors++;
            end
            if (PSLVERR !== expErr) begin
                $display("ERR PSLVERR addr 0x%02h: got 0x%0h expected 0x%0h",
                         PADDR, PSLVERR, expErr);
                errors++;
            end
            // polls and writes carry no expected data
            if (checkRead && !PWRITE && PRDATA !== expData) begin
                $display("ERR PRDATA addr 0x%02h: got 0x%08h expected 0x%08h",
                         PADDR, PRDATA, expData);
                errors++;
            end
        end
    end

endmodule

//--- testbench/rvTop_properties.sv
`timescale 1ns/100ps

module rvTop_properties (
    input logic            clk,
    input logic            rstN,
    input logic            PSEL,
    input logic            PENABLE,
    input logic            PWRITE,
    input rvPkg::apbAddr_t PADDR,
    input logic            PSLVERR,
    input rvPkg::word_t    pc,
    input logic            stallF,
    input logic            coreClear,
    input logic [1:0]      state
);
    import rvPkg::*;

    int   failCount;
    logic done;
    logic ctrlWrite;

    initial begin
        failCount = 0;
    end

    // DONE is the third state of the run FSM
    assign done      = (state == 2'd2);
    assign ctrlWrite = PSEL && PENABLE && PWRITE && (PADDR == REG_CTRL);

    pcHoldOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stallF && !coreClear |=> pc == $past(pc))
        else begin
            $error("PC changed while fetch was stalled");
            failCount++;
        end

    slverrInAccess: assert property (@(posedge clk) disable iff (!rstN)
        PSLVERR |-> PSEL && PENABLE)
        else begin
            $error("PSLVERR raised outside an access phase");
            failCount++;
        end

    doneHeld: assert property (@(posedge clk) disable iff (!rstN)
        done && !ctrlWrite |=> done)
        else begin
            $error("done cleared without a CTRL write");
            failCount++;
        end

endmodule

bind rvTop rvTop_properties props (
    .clk(clk), .rstN(rstN), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PSLVERR(PSLVERR), .pc(uCore.pc), .stallF(uCore.hz.stallF),
    .coreClear(coreClear), .state(uControl.state)
);

//--- testbench/rvTop_stimulus.txt
// columns: kind, APB address, data. kind 1 write, 2 write that must get PSLVERR,
// 3 read expecting data, 4 read that must get PSLVERR, 5 wait for done (data = cycle budget), 0 end
// register block after reset
3 04 00000000
4 20 00000000
2 04 00000001
// arithmetic chain with forwarding, a0 = 1 - 5
1 10 00000000
1 14 FFB00093
1 14 00C08113
1 14 002081B3
1 14 40310233
1 14 002242B3
1 14 0050A333
1 14 40430533
1 14 00100073
3 10 00000008
1 00 00000001
5 00 00000064
3 04 00000001
3 08 FFFFFFFC
3 0C 00000008
// store, load, then an add that uses the load at once
1 10 00000000
1 14 12300093
1 14 00102423
1 14 00802103
1 14 00110533
1 14 00100073
1 00 00000001
5 00 00000064
3 08 00000246
3 0C 00000005
// countdown loop with BNE and a JAL over one ADDI
1 10 00000000
1 14 00300093
1 14 00000513
1 14 00550513
1 14 FFF08093
1 14 FE009CE3
1 14 008002EF
1 14 06450513
1 14 00550533
1 14 00100073
1 00 00000001
// program port is locked while running
2 14 12345678
2 10 00000000
3 04 00000002
3 10 00000009
5 00 000000C8
3 08 00000027
3 0C 0000000E
// rerun from DONE
1 00 00000001
5 00 000000C8
3 08 00000027
3 0C 0000000E
0 00 00000000

//--- testbench/rvTop_tb.sv
`timescale 1ns/100ps

module rvTop_tb;
    import rvPkg::*;

    logic     clk;
    logic     rstN;
    logic     PSEL;
    logic     PENABLE;
    logic     PWRITE;
    apbAddr_t PADDR;
    word_t    PWDATA;
    word_t    PRDATA;
    logic     PREADY;
    logic     PSLVERR;
    logic     checkRead;
    word_t    expData;
    logic     expErr;
    int       compareErrors;
    int       otherFailures;
    int       watchdogCycles;
    word_t    stim [0:255];

    rvTop dut (
        .clk(clk), .rstN(rstN), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
        .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR)
    );

    rvChecker chk (
        .clk(clk), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR),
        .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR), .checkRead(checkRead),
        .expData(expData), .expErr(expErr), .errorCount(compareErrors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // setup cycle then access cycle, read data taken mid-access
    task automatic apbTransfer(input logic write, input apbAddr_t addr, input word_t data,
                               input logic check, input logic err, output word_t rdata);
        @(posedge clk);
        PSEL      <= 1'b1;
        PENABLE   <= 1'b0;
        PWRITE    <= write;
        PADDR     <= addr;
        PWDATA    <= data;
        checkRead <= check;
        expData   <= data;
        expErr    <= err;
        @(posedge clk);
        PENABLE <= 1'b1;
        @(negedge clk);
        rdata = PRDATA;
    endtask

    // polls STATUS, each poll costs two cycles of the budget
    task automatic waitDone(input int budget);
        word_t status;
        int    spent;
        status = '0;
        spent  = 0;
        while (!status[0] && spent < budget) begin
            apbTransfer(1'b0, REG_STATUS, '0, 1'b0, 1'b0, status);
            spent += 2;
        end
        if (!status[0]) begin
            $display("core never halted within %0d cycles", budget);
            otherFailures++;
        end
    endtask

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired before the stimulus list finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int    idx;
        int    total;
        word_t rdata;
        rstN          = 1'b0;
        PSEL          = 1'b0;
        PENABLE       = 1'b0;
        PWRITE        = 1'b0;
        PADDR         = '0;
        PWDATA        = '0;
        checkRead     = 1'b0;
        expData       = '0;
        expErr        = 1'b0;
        otherFailures = 0;
        $readmemh("testbench/rvTop_stimulus.txt", stim);

        // budgets plus two APB cycles per record, reset and some slack
        total = 24;
        for (idx = 0; idx < 253 && stim[idx] != '0; idx += 3) begin
            total += (stim[idx] == 32'd5) ? stim[idx+2] + 2 : 2;
        end
        watchdogCycles = total;

        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        for (idx = 0; idx < 253 && stim[idx] != '0; idx += 3) begin
            case (stim[idx])
                32'd1: apbTransfer(1'b1, stim[idx+1][7:0], stim[idx+2], 1'b0, 1'b0, rdata);
                32'd2: apbTransfer(1'b1, stim[idx+1][7:0], stim[idx+2], 1'b0, 1'b1, rdata);
                32'd3: apbTransfer(1'b0, stim[idx+1][7:0], stim[idx+2], 1'b1, 1'b0, rdata);
                32'd4: apbTransfer(1'b0, stim[idx+1][7:0], stim[idx+2], 1'b0, 1'b1, rdata);
                32'd5: waitDone(stim[idx+2]);
                default: begin
                    $display("unknown record kind %0d at stimulus word %0d", stim[idx], idx);
                    otherFailures++;
                end
            endcase
        end

        @(posedge clk);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d compare, %0d assertion, %0d other",
                 compareErrors, dut.props.failCount, otherFailures);
        if (compareErrors == 0 && otherFailures == 0 && dut.props.failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
